/* build.f */
+incdir+rtl
rtl/camera_pkg.sv
rtl/byte_stream_if.sv
rtl/capture_source.sv
rtl/frame_fifo.sv
rtl/spi_registers.sv
rtl/camera_subsystem.sv
dv/camera_asserts.sv
dv/camera_checker.sv
dv/camera_tb.sv

/* dv/camera_asserts.sv */
`timescale 1ns/1ps

module camera_asserts (
    input logic       clock_in,
    input logic       reset_n_in,
    input logic       response_valid,
    input logic       capture_start,
    input logic       pix_valid,
    input logic       pix_ready,
    input logic [7:0] pix_data,
    input logic       rd_valid,
    input logic       rd_ready
);

    int failures = 0;

    // Response stays idle while reset is held
    response_idle_in_reset: assert property (
        @(posedge clock_in) !reset_n_in |=> !response_valid
    ) else begin
        $error("response_valid high after a reset cycle");
        failures++;
    end

    // Pops only reach a non-empty FIFO
    pop_needs_data: assert property (
        @(posedge clock_in) disable iff (!reset_n_in) rd_ready |-> rd_valid
    ) else begin
        $error("FIFO read ready raised while read valid was low");
        failures++;
    end

    // A new capture may abandon a stalled byte
    source_holds_when_stalled: assert property (
        @(posedge clock_in) disable iff (!reset_n_in)
        pix_valid && !pix_ready && !capture_start |=> pix_valid && $stable(pix_data)
    ) else begin
        $error("pixel source changed or dropped a byte while stalled");
        failures++;
    end

endmodule

/* dv/camera_checker.sv */
`timescale 1ns/1ps

module camera_checker (
    input logic       clock_in,
    input logic       reset_n_in,
    input logic [7:0] op_code,
    input logic       op_code_valid,
    input logic       operand_valid,
    input integer     operand_count,
    input logic [7:0] response,
    input logic       response_valid
);

    logic [7:0] expected_q[$];
    logic [7:0] expected_value;
    logic       op_code_valid_q;
    logic       operand_valid_q;
    logic       sample_due;
    logic [7:0] sample_op;
    integer     sample_index;
    int         checks = 0;
    int         errors = 0;

    task automatic expect_byte(input logic [7:0] value);
        expected_q.push_back(value);
    endtask

    function automatic int pending();
        return expected_q.size();
    endfunction

    // Response is due one cycle after the DUT sees a rising operand_valid
    always @(posedge clock_in) begin
        if (!reset_n_in) begin
            op_code_valid_q <= 1'b0;
            operand_valid_q <= 1'b0;
            sample_due      <= 1'b0;
            sample_op       <= 8'h00;
            sample_index    <= 0;
        end else begin
            op_code_valid_q <= op_code_valid;
            operand_valid_q <= operand_valid;
            sample_due      <= op_code_valid && operand_valid && !operand_valid_q;
            sample_op       <= op_code;
            sample_index    <= operand_count;

            // Response valid trails op_code_valid by one cycle
            if (response_valid !== op_code_valid_q) begin
                errors++;
                $display("Mismatch at %0d ns: response_valid %b a cycle after op_code_valid %b",
                         $time, response_valid, op_code_valid_q);
            end

            if (sample_due) begin
                checks++;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Byte %0d of op 0x%02h came with no expected value queued at %0d ns",
                             sample_index, sample_op, $time);
                end else begin
                    expected_value = expected_q.pop_front();
                    if (!response_valid) begin
                        errors++;
                        $display("response_valid low at %0d ns when byte %0d of op 0x%02h was due",
                                 $time, sample_index, sample_op);
                    end else if (response !== expected_value) begin
                        errors++;
                        $display("Mismatch at %0d ns: op 0x%02h byte %0d expected 0x%02h got 0x%02h",
                                 $time, sample_op, sample_index, expected_value, response);
                    end
                end
            end
        end
    end

endmodule

/* dv/camera_tb.sv */
`timescale 1ns/1ps
`include "camera_config.svh"

module camera_tb
    import camera_pkg::*;
();

    localparam int FRAME_BYTES    = 3 * `CAMERA_FRAME_PIXELS;
    localparam int FIFO_DEPTH     = `CAMERA_FIFO_DEPTH;
    localparam int ZONE_PIXELS    = `CAMERA_FRAME_PIXELS / `CAMERA_ZONES;
    localparam int METERING_BYTES = 9 * `CAMERA_ZONES;
    localparam int FILL_TIMEOUT   = 200;

    logic       clock_in;
    logic       reset_n_in;
    logic [7:0] op_code;
    logic       op_code_valid;
    logic [7:0] operand;
    logic       operand_valid;
    integer     operand_count;
    logic [7:0] response;
    logic       response_valid;

    logic [31:0] rng_state = 32'h9e3b_d12f;
    int          captures = 0;
    int          other_failures = 0;
    int          errors_at_start = 0;
    int          checks_at_start = 0;
    int          cut;

    camera_subsystem dut0 (.*);

    camera_checker checker0 (.*);

    bind camera_subsystem camera_asserts asserts0 (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .response_valid (response_valid),
        .capture_start  (capture_start),
        .pix_valid      (pix_stream.valid),
        .pix_ready      (pix_stream.ready),
        .pix_data       (pix_stream.data),
        .rd_valid       (rd_stream.valid),
        .rd_ready       (rd_stream.ready)
    );

    initial begin
        clock_in = 1'b0;
        forever #2 clock_in = ~clock_in;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Test pattern 16p + 5c + 3k with low bits dropped by the factor
    function automatic logic [7:0] pixel_byte(input int k, input int p, input int c,
                                              input int factor);
        int raw;
        raw = (16 * p + 5 * c + 3 * k) % 256;
        return 8'(raw >> factor);
    endfunction

    function automatic logic [7:0] metering_byte(input int k, input int n);
        int zone;
        int channel;
        int sum;
        zone    = (n / 3) % `CAMERA_ZONES;
        channel = n / (3 * `CAMERA_ZONES);
        sum     = 0;
        for (int p = zone * ZONE_PIXELS; p < (zone + 1) * ZONE_PIXELS; p++) begin
            sum += pixel_byte(k, p, channel, 0);
        end
        // Most significant byte first
        return 8'(sum >> (8 * (2 - n % 3)));
    endfunction

    function automatic int total_errors();
        return checker0.errors + other_failures + dut0.asserts0.failures;
    endfunction

    task automatic spi_command(input camera_op_t op, input int bytes,
                               input logic [7:0] fixed_operand, input bit use_fixed);
        int gap;
        @(posedge clock_in);
        op_code       <= op;
        op_code_valid <= 1'b1;
        for (int i = 0; i < bytes; i++) begin
            rng_state = xorshift32(rng_state);
            gap = 1 + int'(rng_state[7:0] % 3);
            repeat (gap) @(posedge clock_in);
            operand       <= use_fixed ? fixed_operand : rng_state[23:16];
            operand_count <= i;
            operand_valid <= 1'b1;
            @(posedge clock_in);
            operand_valid <= 1'b0;
        end
        // Let the last response be sampled before closing
        repeat (2) @(posedge clock_in);
        op_code_valid <= 1'b0;
        @(posedge clock_in);
    endtask

    task automatic wait_fill(input int expected);
        int cycles;
        cycles = 0;
        while (dut0.fill_count != 16'(expected) && cycles < FILL_TIMEOUT) begin
            @(posedge clock_in);
            cycles++;
        end
        if (dut0.fill_count != 16'(expected)) begin
            $display("Timeout at %0d ns: FIFO fill count never reached %0d", $time, expected);
            other_failures++;
        end
    endtask

    task automatic start_capture();
        spi_command(OP_CAPTURE, 0, 8'h00, 1'b0);
        captures++;
    endtask

    task automatic check_available(input int expected);
        wait_fill(expected);
        checker0.expect_byte(8'(expected >> 8));
        checker0.expect_byte(8'(expected));
        spi_command(OP_BYTES_AVAILABLE, 2, 8'h00, 1'b0);
    endtask

    // Query the fill level, then read that many bytes, until stop
    task automatic read_frame(input int factor, input int stop);
        int done;
        int avail;
        done = 0;
        while (done < stop) begin
            avail = (FRAME_BYTES - done < FIFO_DEPTH) ? FRAME_BYTES - done : FIFO_DEPTH;
            check_available(avail);
            if (avail > stop - done) begin
                avail = stop - done;
            end
            for (int i = done; i < done + avail; i++) begin
                checker0.expect_byte(pixel_byte(captures, i / 3, i % 3, factor));
            end
            spi_command(OP_READ_DATA, avail, 8'h00, 1'b0);
            done += avail;
        end
    endtask

    task automatic finish_test(input string name);
        if (checker0.pending() != 0) begin
            $display("Test %s left %0d expected responses unchecked", name, checker0.pending());
            other_failures++;
        end
        $display("Test %s finished: %0d checks, %0d errors", name,
                 checker0.checks - checks_at_start, total_errors() - errors_at_start);
        checks_at_start = checker0.checks;
        errors_at_start = total_errors();
    endtask

    initial begin
        reset_n_in    <= 1'b0;
        op_code       <= 8'h00;
        op_code_valid <= 1'b0;
        operand       <= 8'h00;
        operand_valid <= 1'b0;
        operand_count <= 0;
        repeat (2) @(posedge clock_in);
        reset_n_in <= 1'b1;

        check_available(0);
        finish_test("reset");

        start_capture();
        read_frame(0, FRAME_BYTES);
        finish_test("full frame");

        checker0.expect_byte(8'h00);
        spi_command(OP_COMPRESSION, 1, 8'h02, 1'b1);
        start_capture();
        read_frame(2, FRAME_BYTES);
        finish_test("compression");

        for (int n = 0; n < METERING_BYTES; n++) begin
            checker0.expect_byte(metering_byte(captures, n));
        end
        spi_command(OP_METERING, METERING_BYTES, 8'h00, 1'b0);
        finish_test("metering");

        // Abandon part of a frame, then capture again
        start_capture();
        rng_state = xorshift32(rng_state);
        cut = 1 + int'(rng_state % (FRAME_BYTES - 1));
        read_frame(2, cut);
        start_capture();
        read_frame(2, FRAME_BYTES);
        finish_test("restart");

        checker0.expect_byte(8'h00);
        spi_command(OP_READ_DATA, 1, 8'h00, 1'b0);
        check_available(0);
        finish_test("empty read");

        $display("Totals: %0d checks, %0d errors", checker0.checks, total_errors());
        if (total_errors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rtl/byte_stream_if.sv */
`timescale 1ns/1ps

interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    // Final byte of a frame
    logic       last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

/* rtl/camera_config.svh */
`ifndef CAMERA_CONFIG_SVH
`define CAMERA_CONFIG_SVH

// Frame geometry of the test-pattern sensor
`define CAMERA_FRAME_PIXELS 20

// Metering zones as equal runs of pixels
`define CAMERA_ZONES 5

// Buffer depth below one frame so the source sees back-pressure
`define CAMERA_FIFO_DEPTH 16

// SPI op codes
`define CAMERA_OP_CAPTURE         8'h20
`define CAMERA_OP_BYTES_AVAILABLE 8'h21
`define CAMERA_OP_READ_DATA       8'h22
`define CAMERA_OP_ZOOM            8'h23
`define CAMERA_OP_PAN             8'h24
`define CAMERA_OP_METERING        8'h25
`define CAMERA_OP_COMPRESSION     8'h26

`endif

/* rtl/camera_pkg.sv */
`include "camera_config.svh"

package camera_pkg;

    // Op codes seen on the SPI register interface
    typedef enum logic [7:0] {
        OP_CAPTURE         = `CAMERA_OP_CAPTURE,
        OP_BYTES_AVAILABLE = `CAMERA_OP_BYTES_AVAILABLE,
        OP_READ_DATA       = `CAMERA_OP_READ_DATA,
        OP_ZOOM            = `CAMERA_OP_ZOOM,
        OP_PAN             = `CAMERA_OP_PAN,
        OP_METERING        = `CAMERA_OP_METERING,
        OP_COMPRESSION     = `CAMERA_OP_COMPRESSION
    } camera_op_t;

    // Colour sums for one zone
    typedef struct packed {
        logic [23:0] red;
        logic [23:0] green;
        logic [23:0] blue;
    } metering_t;

    // One entry per zone with zone 0 at index 0
    typedef metering_t [`CAMERA_ZONES-1:0] metering_array_t;

endpackage

/* rtl/camera_subsystem.sv */
`timescale 1ns/1ps

module camera_subsystem
    import camera_pkg::*;
(
    input  logic       clock_in,
    input  logic       reset_n_in,
    input  logic [7:0] op_code,
    input  logic       op_code_valid,
    input  logic [7:0] operand,
    input  logic       operand_valid,
    input  integer     operand_count,
    output logic [7:0] response,
    output logic       response_valid
);

    logic            capture_start;
    logic [3:0]      compression_factor;
    logic [15:0]     fill_count;
    metering_array_t metering;

    // Sensor to buffer, buffer to register block
    byte_stream_if pix_stream ();
    byte_stream_if rd_stream ();

    capture_source capture_source0 (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .capture_start      (capture_start),
        .compression_factor (compression_factor),
        .pix_out            (pix_stream.source),
        .metering           (metering)
    );

    // New capture also discards the old frame
    frame_fifo frame_fifo0 (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .flush      (capture_start),
        .wr         (pix_stream.sink),
        .rd         (rd_stream.source),
        .fill_count (fill_count)
    );

    spi_registers spi_registers0 (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .op_code            (op_code),
        .op_code_valid      (op_code_valid),
        .operand            (operand),
        .operand_valid      (operand_valid),
        .operand_count      (operand_count),
        .response           (response),
        .response_valid     (response_valid),
        .capture_start      (capture_start),
        .compression_factor (compression_factor),
        .rd_in              (rd_stream.sink),
        .fill_count         (fill_count),
        .metering           (metering)
    );

endmodule

/* rtl/capture_source.sv */
`timescale 1ns/1ps
`include "camera_config.svh"

module capture_source
    import camera_pkg::*;
(
    input  logic             clock_in,
    input  logic             reset_n_in,
    input  logic             capture_start,
    input  logic [3:0]       compression_factor,
    byte_stream_if.source    pix_out,
    output metering_array_t  metering
);

    localparam int PIXELS      = `CAMERA_FRAME_PIXELS;
    localparam int ZONE_PIXELS = `CAMERA_FRAME_PIXELS / `CAMERA_ZONES;
    localparam int PIXEL_W     = $clog2(PIXELS);

    logic [7:0]         capture_count;
    logic [PIXEL_W-1:0] pixel;
    logic [1:0]         channel;
    logic               active;
    logic [7:0]         channel_offset;
    logic [7:0]         capture_offset;
    logic [7:0]         raw_byte;
    logic               final_byte;
    logic               load;
    int                 zone;
    metering_array_t    zone_sums;

    // Pattern is 16p + 5c + 3k, wrapping at 256
    assign channel_offset = 8'({channel, 2'b00}) + 8'(channel);
    assign capture_offset = {capture_count[6:0], 1'b0} + capture_count;
    assign raw_byte       = {pixel[3:0], 4'b0000} + channel_offset + capture_offset;

    assign final_byte = (pixel == PIXEL_W'(PIXELS - 1)) && (channel == 2'd2);

    // Next byte goes out when the output register is empty or draining
    assign load = active && (!pix_out.valid || pix_out.ready);

    assign zone     = int'(pixel) / ZONE_PIXELS;
    assign metering = zone_sums;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            capture_count <= '0;
            pixel         <= '0;
            channel       <= '0;
            active        <= 1'b0;
            pix_out.valid <= 1'b0;
            zone_sums     <= '0;
        end else if (capture_start) begin
            // First frame after reset uses k = 1
            capture_count <= capture_count + 8'd1;
            pixel         <= '0;
            channel       <= '0;
            active        <= 1'b1;
            pix_out.valid <= 1'b0;
            zone_sums     <= '0;
        end else begin
            if (pix_out.valid && pix_out.ready) begin
                pix_out.valid <= 1'b0;
            end

            if (load) begin
                pix_out.valid <= 1'b1;

                // Metering sees the uncompressed byte
                case (channel)
                    2'd0: zone_sums[zone].red <= zone_sums[zone].red + 24'(raw_byte);
                    2'd1: zone_sums[zone].green <= zone_sums[zone].green + 24'(raw_byte);
                    default: zone_sums[zone].blue <= zone_sums[zone].blue + 24'(raw_byte);
                endcase

                if (channel == 2'd2) begin
                    channel <= '0;
                    pixel   <= pixel + 1'b1;
                end else begin
                    channel <= channel + 2'd1;
                end

                if (final_byte) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Output payload with low bits dropped by compression
    always_ff @(posedge clock_in) begin
        if (load) begin
            pix_out.data <= raw_byte >> compression_factor;
            pix_out.last <= final_byte;
        end
    end

endmodule

/* rtl/frame_fifo.sv */
`timescale 1ns/1ps
`include "camera_config.svh"

module frame_fifo (
    input  logic          clock_in,
    input  logic          reset_n_in,
    input  logic          flush,
    byte_stream_if.sink   wr,
    byte_stream_if.source rd,
    output logic [15:0]   fill_count
);

    localparam int DEPTH  = `CAMERA_FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    // Each entry holds {last, data}
    logic [8:0]        mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              push;
    logic              pop;

    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
        if (ptr == ADDR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr.ready = (count != (ADDR_W + 1)'(DEPTH));
    assign push     = wr.valid && wr.ready;

    // Head is visible straight from the array
    assign rd.valid = (count != '0);
    assign rd.data  = mem[rd_ptr][7:0];
    assign rd.last  = mem[rd_ptr][8];
    assign pop      = rd.valid && rd.ready;

    assign fill_count = 16'(count);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Flush wins over any push in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock_in) begin
        if (push && !flush) begin
            mem[wr_ptr] <= {wr.last, wr.data};
        end
    end

endmodule

/* rtl/spi_registers.sv */
`timescale 1ns/1ps
`include "camera_config.svh"

module spi_registers
    import camera_pkg::*;
(
    input  logic            clock_in,
    input  logic            reset_n_in,
    input  logic [7:0]      op_code,
    input  logic            op_code_valid,
    input  logic [7:0]      operand,
    input  logic            operand_valid,
    input  integer          operand_count,
    output logic [7:0]      response,
    output logic            response_valid,
    output logic            capture_start,
    output logic [3:0]      compression_factor,
    byte_stream_if.sink     rd_in,
    input  logic [15:0]     fill_count,
    input  metering_array_t metering
);

    // Three channels, three bytes each, per zone
    localparam int METERING_BYTES = 3 * 3 * `CAMERA_ZONES;

    camera_op_t  op;
    logic        op_code_valid_q;
    logic        operand_valid_q;
    logic        transaction_start;
    logic        operand_rise;
    logic        pop_pending;
    int          meter_zone;
    int          meter_channel;
    int          meter_lane;
    logic [23:0] meter_word;
    logic [7:0]  meter_byte;

    assign op                = camera_op_t'(op_code);
    assign transaction_start = op_code_valid && !op_code_valid_q;
    assign operand_rise      = operand_valid && !operand_valid_q;

    // One-cycle pop strobe after a rising operand_valid
    assign rd_in.ready = pop_pending;

    // Byte n takes channel n/15 and zone (n/3) mod 5 with the MSB first
    always_comb begin
        meter_zone    = (operand_count / 3) % `CAMERA_ZONES;
        meter_channel = operand_count / (3 * `CAMERA_ZONES);
        meter_lane    = operand_count % 3;

        case (meter_channel)
            0:       meter_word = metering[meter_zone].red;
            1:       meter_word = metering[meter_zone].green;
            default: meter_word = metering[meter_zone].blue;
        endcase

        case (meter_lane)
            0:       meter_byte = meter_word[23:16];
            1:       meter_byte = meter_word[15:8];
            default: meter_byte = meter_word[7:0];
        endcase

        if (operand_count < 0 || operand_count >= METERING_BYTES) begin
            meter_byte = 8'h00;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            op_code_valid_q    <= 1'b0;
            operand_valid_q    <= 1'b0;
            response           <= 8'h00;
            response_valid     <= 1'b0;
            capture_start      <= 1'b0;
            compression_factor <= 4'h0;
            pop_pending        <= 1'b0;
        end else begin
            op_code_valid_q <= op_code_valid;
            operand_valid_q <= operand_valid;
            response_valid  <= op_code_valid;

            // Single pulse per capture transaction
            capture_start <= transaction_start && (op == OP_CAPTURE);

            // Pop only when a head byte was there to answer with
            pop_pending <= op_code_valid && (op == OP_READ_DATA) && operand_rise
                           && rd_in.valid;

            if (op_code_valid) begin
                case (op)
                    OP_BYTES_AVAILABLE: begin
                        case (operand_count)
                            0:       response <= fill_count[15:8];
                            1:       response <= fill_count[7:0];
                            default: response <= 8'h00;
                        endcase
                    end

                    OP_READ_DATA: begin
                        response <= rd_in.valid ? rd_in.data : 8'h00;
                    end

                    OP_METERING: begin
                        response <= meter_byte;
                    end

                    OP_COMPRESSION: begin
                        if (operand_valid) begin
                            compression_factor <= operand[3:0];
                        end
                        response <= 8'h00;
                    end

                    // Capture, zoom, pan and unknown codes answer zero
                    default: response <= 8'h00;
                endcase
            end
        end
    end

endmodule
